//--- pipe_settings.svh
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////
`define PIPE_XLEN        16  // Register and memory word width
`define PIPE_NREG        8   // Architectural registers
`define PIPE_DMEM_WORDS  16  // Data memory words

////////////////////////////////////////////////////////////
// Flow control and trace
////////////////////////////////////////////////////////////
`define PIPE_IQ_DEPTH    4   // Input queue entries and initial sender credits
`define PIPE_TRACE_DEPTH 8   // Record FIFO entries and initial trace credits

// Tags wrap at 2**PIPE_TAG_W, which must cover PIPE_TRACE_DEPTH
`define PIPE_TAG_W       3
`define PIPE_CYC_W       16  // Cycle stamp width

`endif

//--- pipe_pkg.sv
`include "pipe_settings.svh"

package pipe_pkg;

    typedef logic [`PIPE_XLEN-1:0]         word_t;
    typedef logic [15:0]                   instr_t;    // op 15:13 rd 12:10 rs 9:7 rt 6:4
    typedef logic [$clog2(`PIPE_NREG)-1:0] reg_idx_t;
    typedef logic [`PIPE_TAG_W-1:0]        tag_t;      // Sequence number modulo 8
    typedef logic [`PIPE_CYC_W-1:0]        cycle_t;

    ////////////////////////////////////////////////////////////
    // Instruction set
    //   ADD SUB AND XOR  rd <= rs op rt
    //   LDI              rd <= imm (bits 6:0, zero-extended)
    //   LD               rd <= mem[(rs + imm) low 4 bits]
    //   ST               mem[(rs + imm) low 4 bits] <= rd
    //   NOP              no effect
    // Only ALU ops, LDI and LD write a register
    // Registers read as zero after reset
    // Data memory is undefined until stored
    ////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_LDI = 3'd4,
        OP_LD  = 3'd5,
        OP_ST  = 3'd6,
        OP_NOP = 3'd7
    } opcode_e;

    typedef struct packed {
        logic valid;  // Tagged instruction occupies the stage this cycle
        tag_t tag;
    } stage_evt_t;

    typedef struct packed {
        stage_evt_t evt_if;
        stage_evt_t evt_id;
        stage_evt_t evt_ex;
        stage_evt_t evt_mem;
        stage_evt_t evt_wb;
    } stage_evts_t;

    typedef struct packed {
        logic     valid;
        tag_t     tag;
        instr_t   instr;
        logic     wen;    // Register write happened
        reg_idx_t rd;
        word_t    value;
    } wb_info_t;

    typedef struct packed {
        tag_t     tag;
        instr_t   instr;
        logic     wen;
        reg_idx_t rd;
        word_t    value;
        cycle_t   cyc_if;  // First cycle in each stage
        cycle_t   cyc_id;
        cycle_t   cyc_ex;
        cycle_t   cyc_mem;
        cycle_t   cyc_wb;
    } trace_rec_t;

endpackage

//--- pipe_fetch.sv
`timescale 1ns/1ps
`include "pipe_settings.svh"

module pipe_fetch
    import pipe_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   instr_valid,
    input  instr_t instr,
    output logic   instr_credit,
    input  logic   issue_ok,
    input  logic   stall_id,
    output logic   if_valid,
    output tag_t   if_tag,
    output instr_t if_instr
);

    localparam int DEPTH = `PIPE_IQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    instr_t           iq_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   iq_count;
    logic             pop;
    tag_t             next_tag;

    ////////////////////////////////////////////////////////////
    // Input queue
    ////////////////////////////////////////////////////////////
    // The sender holds a credit for every push, so no full check
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            iq_mem[wr_ptr] <= instr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            iq_count <= '0;
        end else begin
            if (instr_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({instr_valid, pop})
                2'b10:   iq_count <= iq_count + 1'b1;
                2'b01:   iq_count <= iq_count - 1'b1;
                default: iq_count <= iq_count;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // IF stage
    ////////////////////////////////////////////////////////////
    assign if_valid = (iq_count != '0) && issue_ok;  // Queue head is the IF entry
    assign if_instr = iq_mem[rd_ptr];
    assign if_tag   = next_tag;
    assign pop      = if_valid && !stall_id;         // Held in IF while decode stalls

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            next_tag     <= '0;
            instr_credit <= 1'b0;
        end else begin
            instr_credit <= pop;  // One credit back per pop
            if (pop) begin
                next_tag <= next_tag + 1'b1;
            end
        end
    end

endmodule

//--- pipe_core.sv
`timescale 1ns/1ps
`include "pipe_settings.svh"

module pipe_core
    import pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        if_valid,
    input  tag_t        if_tag,
    input  instr_t      if_instr,
    output logic        stall_id,
    output stage_evts_t stage_evts,
    output wb_info_t    wb_info
);

    localparam int DADDR_W = $clog2(`PIPE_DMEM_WORDS);

    word_t rf   [`PIPE_NREG];
    word_t dmem [`PIPE_DMEM_WORDS];

    logic         id_valid;
    tag_t         id_tag;
    instr_t       id_instr;
    logic         ex_valid;
    tag_t         ex_tag;
    instr_t       ex_instr;
    word_t        ex_rs_val;
    word_t        ex_rt_val;
    word_t        ex_rd_val;
    logic         mem_valid;
    tag_t         mem_tag;
    instr_t       mem_instr;
    logic         mem_wen;
    reg_idx_t     mem_rd;
    word_t        mem_alu;      // ALU result or memory address
    word_t        mem_st_data;
    logic         wb_valid;
    tag_t         wb_tag;
    instr_t       wb_instr;
    logic         wb_wen;
    reg_idx_t     wb_rd;
    word_t        wb_value;

    opcode_e      id_op;
    logic         uses_rs;
    logic         uses_rt;
    logic         uses_rd;
    logic         ex_is_ld;
    word_t        id_rs_val;
    word_t        id_rt_val;
    word_t        id_rd_val;
    opcode_e      ex_op;
    word_t        op_a;
    word_t        op_b;
    word_t        op_c;
    word_t        ex_result;
    logic         ex_wen;
    opcode_e      mem_op;
    logic [DADDR_W-1:0] mem_addr;
    word_t        mem_value;

    function automatic opcode_e op_of(instr_t i);
        return opcode_e'(i[15:13]);
    endfunction

    // Youngest matching writer wins over the older value
    function automatic word_t fwd(reg_idx_t idx, word_t raw, logic wen, reg_idx_t wrd,
                                  word_t wval);
        return (wen && wrd == idx) ? wval : raw;
    endfunction

    ////////////////////////////////////////////////////////////
    // Decode and load-use detect
    ////////////////////////////////////////////////////////////
    assign id_op    = op_of(id_instr);
    assign uses_rt  = id_op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR};
    assign uses_rs  = uses_rt || (id_op inside {OP_LD, OP_ST});
    assign uses_rd  = (id_op == OP_ST);  // Store data comes from rd
    assign ex_is_ld = ex_valid && (ex_op == OP_LD);

    assign stall_id = id_valid && ex_is_ld &&
                      ((uses_rs && id_instr[9:7] == ex_instr[12:10]) ||
                       (uses_rt && id_instr[6:4] == ex_instr[12:10]) ||
                       (uses_rd && id_instr[12:10] == ex_instr[12:10]));

    // Register file read after the WB write
    assign id_rs_val = fwd(id_instr[9:7], rf[id_instr[9:7]], wb_wen, wb_rd, wb_value);
    assign id_rt_val = fwd(id_instr[6:4], rf[id_instr[6:4]], wb_wen, wb_rd, wb_value);
    assign id_rd_val = fwd(id_instr[12:10], rf[id_instr[12:10]], wb_wen, wb_rd, wb_value);

    ////////////////////////////////////////////////////////////
    // Execute with forwarding from MEM and WB
    ////////////////////////////////////////////////////////////
    assign ex_op = op_of(ex_instr);
    assign op_a  = fwd(ex_instr[9:7], fwd(ex_instr[9:7], ex_rs_val, wb_wen, wb_rd, wb_value),
                       mem_wen, mem_rd, mem_value);
    assign op_b  = fwd(ex_instr[6:4], fwd(ex_instr[6:4], ex_rt_val, wb_wen, wb_rd, wb_value),
                       mem_wen, mem_rd, mem_value);
    assign op_c  = fwd(ex_instr[12:10],
                       fwd(ex_instr[12:10], ex_rd_val, wb_wen, wb_rd, wb_value),
                       mem_wen, mem_rd, mem_value);

    always_comb begin
        case (ex_op)
            OP_ADD:       ex_result = op_a + op_b;
            OP_SUB:       ex_result = op_a - op_b;
            OP_AND:       ex_result = op_a & op_b;
            OP_XOR:       ex_result = op_a ^ op_b;
            OP_LDI:       ex_result = word_t'(ex_instr[6:0]);
            OP_LD, OP_ST: ex_result = op_a + word_t'(ex_instr[6:0]);  // Address
            default:      ex_result = '0;
        endcase
    end

    assign ex_wen = ex_valid && (ex_op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_LDI, OP_LD});

    ////////////////////////////////////////////////////////////
    // Memory stage
    ////////////////////////////////////////////////////////////
    assign mem_op    = op_of(mem_instr);
    assign mem_addr  = mem_alu[DADDR_W-1:0];
    assign mem_value = (mem_op == OP_LD) ? dmem[mem_addr] : mem_alu;

    always_ff @(posedge clk) begin
        if (mem_valid && mem_op == OP_ST) begin
            dmem[mem_addr] <= mem_st_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `PIPE_NREG; i++) begin
                rf[i] <= '0;
            end
        end else if (wb_wen) begin
            rf[wb_rd] <= wb_value;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_valid  <= 1'b0;
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            mem_wen   <= 1'b0;
            wb_valid  <= 1'b0;
            wb_wen    <= 1'b0;
        end else begin
            if (!stall_id) begin
                id_valid <= if_valid;
            end
            ex_valid  <= id_valid && !stall_id;  // Bubble on load-use
            mem_valid <= ex_valid;
            mem_wen   <= ex_wen;
            wb_valid  <= mem_valid;
            wb_wen    <= mem_wen;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_id) begin
            id_tag   <= if_tag;
            id_instr <= if_instr;
        end
        ex_tag      <= id_tag;
        ex_instr    <= id_instr;
        ex_rs_val   <= id_rs_val;
        ex_rt_val   <= id_rt_val;
        ex_rd_val   <= id_rd_val;
        mem_tag     <= ex_tag;
        mem_instr   <= ex_instr;
        mem_rd      <= ex_instr[12:10];
        mem_alu     <= ex_result;
        mem_st_data <= op_c;
        wb_tag      <= mem_tag;
        wb_instr    <= mem_instr;
        wb_rd       <= mem_rd;
        wb_value    <= mem_value;
    end

    always_comb begin
        stage_evts.evt_if.valid  = if_valid && !stall_id;  // Stamped in the pop cycle
        stage_evts.evt_if.tag    = if_tag;
        stage_evts.evt_id.valid  = id_valid;
        stage_evts.evt_id.tag    = id_tag;
        stage_evts.evt_ex.valid  = ex_valid;
        stage_evts.evt_ex.tag    = ex_tag;
        stage_evts.evt_mem.valid = mem_valid;
        stage_evts.evt_mem.tag   = mem_tag;
        stage_evts.evt_wb.valid  = wb_valid;
        stage_evts.evt_wb.tag    = wb_tag;
        wb_info.valid            = wb_valid;
        wb_info.tag              = wb_tag;
        wb_info.instr            = wb_instr;
        wb_info.wen              = wb_wen;
        wb_info.rd               = wb_rd;
        wb_info.value            = wb_value;
    end

endmodule

//--- pipe_trace.sv
`timescale 1ns/1ps
`include "pipe_settings.svh"

module pipe_trace
    import pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  stage_evts_t stage_evts,
    input  wb_info_t    wb_info,
    output logic        issue_ok,
    output logic        trace_valid,
    output trace_rec_t  trace_rec,
    input  logic        trace_credit
);

    localparam int DEPTH = `PIPE_TRACE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int NTAGS = 1 << `PIPE_TAG_W;

    cycle_t           cyc;
    stage_evts_t      prev_evts;      // Events of the previous cycle
    cycle_t           tab_if  [NTAGS];
    cycle_t           tab_id  [NTAGS];
    cycle_t           tab_ex  [NTAGS];
    cycle_t           tab_mem [NTAGS];
    trace_rec_t       wb_rec;
    trace_rec_t       fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fifo_count;
    logic [PTR_W:0]   credits;
    logic [PTR_W:0]   occ;            // In flight plus queued
    logic             push;
    logic             send;

    // True on the first cycle a tag shows up in a stage
    function automatic logic is_new(stage_evt_t cur, stage_evt_t prev);
        return cur.valid && !(prev.valid && prev.tag == cur.tag);
    endfunction

    function automatic logic [PTR_W:0] bump(logic [PTR_W:0] v, logic up, logic dn);
        return v + {{PTR_W{1'b0}}, up} - {{PTR_W{1'b0}}, dn};
    endfunction

    ////////////////////////////////////////////////////////////
    // Cycle stamps per tag
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cyc       <= '0;
            prev_evts <= '0;
        end else begin
            cyc       <= cyc + 1'b1;
            prev_evts <= stage_evts;
        end
    end

    always_ff @(posedge clk) begin
        if (is_new(stage_evts.evt_if, prev_evts.evt_if)) begin
            tab_if[stage_evts.evt_if.tag] <= cyc;
        end
        if (is_new(stage_evts.evt_id, prev_evts.evt_id)) begin
            tab_id[stage_evts.evt_id.tag] <= cyc;  // Stall keeps the first ID cycle
        end
        if (is_new(stage_evts.evt_ex, prev_evts.evt_ex)) begin
            tab_ex[stage_evts.evt_ex.tag] <= cyc;
        end
        if (is_new(stage_evts.evt_mem, prev_evts.evt_mem)) begin
            tab_mem[stage_evts.evt_mem.tag] <= cyc;
        end
    end

    always_comb begin
        wb_rec.tag     = wb_info.tag;
        wb_rec.instr   = wb_info.instr;
        wb_rec.wen     = wb_info.wen;
        wb_rec.rd      = wb_info.rd;
        wb_rec.value   = wb_info.value;
        wb_rec.cyc_if  = tab_if[wb_info.tag];
        wb_rec.cyc_id  = tab_id[wb_info.tag];
        wb_rec.cyc_ex  = tab_ex[wb_info.tag];
        wb_rec.cyc_mem = tab_mem[wb_info.tag];
        wb_rec.cyc_wb  = cyc;
    end

    ////////////////////////////////////////////////////////////
    // Record FIFO and credit output
    ////////////////////////////////////////////////////////////
    assign push        = wb_info.valid;
    assign send        = trace_valid;
    assign trace_valid = (fifo_count != '0) && (credits != '0);
    assign trace_rec   = fifo_mem[rd_ptr];
    assign issue_ok    = occ < (PTR_W+1)'(DEPTH);  // Table and FIFO cannot overrun

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= wb_rec;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
            credits    <= (PTR_W+1)'(DEPTH);
            occ        <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fifo_count <= bump(fifo_count, push, send);
            credits    <= bump(credits, trace_credit, send);
            occ        <= bump(occ, stage_evts.evt_if.valid, send);
        end
    end

endmodule

//--- pipe_top.sv
`timescale 1ns/1ps

module pipe_top
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       instr_valid,
    input  instr_t     instr,
    output logic       instr_credit,
    output logic       trace_valid,
    output trace_rec_t trace_rec,
    input  logic       trace_credit
);

    logic        issue_ok;
    logic        stall_id;
    logic        if_valid;
    tag_t        if_tag;
    instr_t      if_instr;
    stage_evts_t stage_evts;
    wb_info_t    wb_info;

    pipe_fetch pipe_fetch_inst (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_credit (instr_credit),
        .issue_ok     (issue_ok),
        .stall_id     (stall_id),
        .if_valid     (if_valid),
        .if_tag       (if_tag),
        .if_instr     (if_instr)
    );

    pipe_core pipe_core_inst (
        .clk        (clk),
        .rst        (rst),
        .if_valid   (if_valid),
        .if_tag     (if_tag),
        .if_instr   (if_instr),
        .stall_id   (stall_id),
        .stage_evts (stage_evts),
        .wb_info    (wb_info)
    );

    pipe_trace pipe_trace_inst (
        .clk          (clk),
        .rst          (rst),
        .stage_evts   (stage_evts),
        .wb_info      (wb_info),
        .issue_ok     (issue_ok),
        .trace_valid  (trace_valid),
        .trace_rec    (trace_rec),
        .trace_credit (trace_credit)
    );

endmodule

//--- pipe_chk.sv
`timescale 1ns/1ps
`include "pipe_settings.svh"

module pipe_chk
    import pipe_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        instr_valid,
    input logic        instr_credit,
    input logic        trace_valid,
    input logic        trace_credit,
    input stage_evts_t stage_evts
);

    logic [4:0] trace_credits;   // Credits the trace port holds
    logic [4:0] iq_outstanding;  // Accepted but not yet credited back

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trace_credits  <= 5'(`PIPE_TRACE_DEPTH);
            iq_outstanding <= '0;
        end else begin
            trace_credits  <= trace_credits + 5'(trace_credit) - 5'(trace_valid);
            iq_outstanding <= iq_outstanding + 5'(instr_valid) - 5'(instr_credit);
        end
    end

    a_trace_credit: assert property (@(posedge clk) disable iff (rst)
        trace_valid |-> trace_credits != '0)
        else $error("trace_valid raised with no trace credit left");

    a_instr_credit: assert property (@(posedge clk) disable iff (rst)
        instr_credit |-> iq_outstanding != '0)
        else $error("instr_credit returned more credits than instructions accepted");

    a_evts_reset: assert property (@(posedge clk)
        $fell(rst) |-> !(stage_evts.evt_if.valid || stage_evts.evt_id.valid ||
                         stage_evts.evt_ex.valid || stage_evts.evt_mem.valid ||
                         stage_evts.evt_wb.valid))
        else $error("Stage event valid high in the first cycle after reset");

endmodule

bind pipe_top pipe_chk pipe_chk_inst (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .instr_credit (instr_credit),
    .trace_valid  (trace_valid),
    .trace_credit (trace_credit),
    .stage_evts   (stage_evts)
);

//--- tb_pipe.sv
`timescale 1ns/1ps
`include "pipe_settings.svh"

module tb_pipe
    import pipe_pkg::*;
;

    localparam int TIMEOUT     = 2000;  // Cycles per wait loop
    localparam int TRACE_DEPTH = `PIPE_TRACE_DEPTH;

    typedef struct packed {
        instr_t   instr;
        logic     wen;
        reg_idx_t rd;
        word_t    value;
    } exp_t;

    logic       clk;
    logic       rst;
    logic       instr_valid;
    instr_t     instr;
    logic       instr_credit;
    logic       trace_valid;
    trace_rec_t trace_rec;
    logic       trace_credit;

    word_t       m_reg [`PIPE_NREG];        // Model register file
    word_t       m_mem [`PIPE_DMEM_WORDS];  // Model data memory
    instr_t      send_q [$];
    exp_t        exp_q [$];
    trace_rec_t  rec_q [$];
    logic [31:0] gen_rng = 32'd83;
    logic [31:0] gap_rng = 32'd83;
    logic        hold = 1'b0;               // Receiver withholds trace credits
    int          hold_recs = 0;
    int          n_queued = 0;
    int          n_checked = 0;
    int          n_stalls = 0;
    int          errors = 0;
    int          test_err0 = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic        prev_valid = 1'b0;
    cycle_t      prev_ex;
    instr_t      prev_instr;

    pipe_top pipe_top_inst (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_credit (instr_credit),
        .trace_valid  (trace_valid),
        .trace_rec    (trace_rec),
        .trace_credit (trace_credit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic instr_t enc(input opcode_e op, input reg_idx_t rd, input reg_idx_t rs,
                                   input logic [6:0] low);
        return {op, rd, rs, low};
    endfunction

    function automatic exp_t ref_exec(input instr_t i);
        exp_t       e;
        reg_idx_t   rd;
        reg_idx_t   rs;
        reg_idx_t   rt;
        logic [3:0] addr;
        rd      = i[12:10];
        rs      = i[9:7];
        rt      = i[6:4];
        addr    = 4'(m_reg[rs] + word_t'(i[6:0]));  // Low 4 bits of rs + imm
        e.instr = i;
        e.rd    = rd;
        e.wen   = 1'b1;
        e.value = '0;
        case (opcode_e'(i[15:13]))
            OP_ADD:  e.value = m_reg[rs] + m_reg[rt];
            OP_SUB:  e.value = m_reg[rs] - m_reg[rt];
            OP_AND:  e.value = m_reg[rs] & m_reg[rt];
            OP_XOR:  e.value = m_reg[rs] ^ m_reg[rt];
            OP_LDI:  e.value = word_t'(i[6:0]);
            OP_LD:   e.value = m_mem[addr];
            OP_ST: begin
                m_mem[addr] = m_reg[rd];
                e.wen       = 1'b0;
            end
            default: e.wen = 1'b0;
        endcase
        if (e.wen) begin
            m_reg[rd] = e.value;
        end
        return e;
    endfunction

    // Registers that decode compares against a load in EX
    function automatic logic reads_reg(input instr_t i, input reg_idx_t r);
        case (opcode_e'(i[15:13]))
            OP_ADD, OP_SUB, OP_AND, OP_XOR: return i[9:7] == r || i[6:4] == r;
            OP_LD:   return i[9:7] == r;
            OP_ST:   return i[9:7] == r || i[12:10] == r;
            default: return 1'b0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: record %0d %s got %h expected %h", $time, n_checked, what,
                     got, exp);
        end
    endtask

    task automatic check_cycle(input string what, input cycle_t got, input cycle_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: record %0d %s got %0d expected %0d", $time, n_checked, what,
                     got, exp);
        end
    endtask

    task automatic check_reg(input string what, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: record %0d %s got r%0d expected r%0d", $time, n_checked, what,
                     got, exp);
        end
    endtask

    task automatic check_tag(input string what, input tag_t got, input tag_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: record %0d %s got %0d expected %0d", $time, n_checked, what,
                     got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: record %0d %s got %b expected %b", $time, n_checked, what,
                     got, exp);
        end
    endtask

    task automatic compare_record(input trace_rec_t r);
        exp_t e;
        logic ld_use;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Trace record with tag %0d arrived with no instruction left to match",
                     r.tag);
            return;
        end
        e = exp_q.pop_front();
        check_tag("tag", r.tag, tag_t'(n_checked));  // Tags count modulo 8
        check_word("instr", r.instr, e.instr);
        check_flag("wen", r.wen, e.wen);
        check_reg("rd", r.rd, e.rd);
        if (e.wen) begin
            check_word("value", r.value, e.value);
        end
        // Stall only when the load sat in EX while this one was first in ID
        ld_use = prev_valid && opcode_e'(prev_instr[15:13]) == OP_LD &&
                 reads_reg(e.instr, prev_instr[12:10]) && prev_ex == r.cyc_id;
        if (ld_use) begin
            n_stalls++;
        end
        check_cycle("ID stamp", r.cyc_id, r.cyc_if + 1'b1);
        check_cycle("EX stamp", r.cyc_ex, r.cyc_id + (ld_use ? 16'd2 : 16'd1));
        check_cycle("MEM stamp", r.cyc_mem, r.cyc_ex + 1'b1);
        check_cycle("WB stamp", r.cyc_wb, r.cyc_mem + 1'b1);
        prev_valid = 1'b1;
        prev_ex    = r.cyc_ex;
        prev_instr = e.instr;
        n_checked++;
    endtask

    always @(posedge clk) begin
        while (rec_q.size() > 0) begin
            compare_record(rec_q.pop_front());
        end
    end

    ////////////////////////////////////////////////////////////
    // Sender and receiver
    ////////////////////////////////////////////////////////////
    initial begin : sender
        int credits;
        credits     = `PIPE_IQ_DEPTH;
        instr_valid = 1'b0;
        instr       = '0;
        forever begin
            @(negedge clk);
            if (instr_credit) begin
                credits++;
            end
            if (!rst && credits > 0 && send_q.size() > 0) begin
                instr_valid = 1'b1;
                instr       = send_q.pop_front();
                credits--;
            end else begin
                instr_valid = 1'b0;
            end
        end
    end

    initial begin : receiver
        int owed;
        owed         = 0;
        trace_credit = 1'b0;
        forever begin
            @(negedge clk);
            if (trace_valid) begin
                rec_q.push_back(trace_rec);
                owed++;
                if (hold) begin
                    hold_recs++;
                end
            end
            gap_rng = xorshift(gap_rng);
            if (!hold && owed > 0 && gap_rng[1:0] != 2'b00) begin  // Random gaps
                trace_credit = 1'b1;
                owed--;
            end else begin
                trace_credit = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequencing
    ////////////////////////////////////////////////////////////
    task automatic issue(input instr_t i);
        send_q.push_back(i);
        exp_q.push_back(ref_exec(i));
        n_queued++;
    endtask

    task automatic issue_random(input int count, input logic alu_only);
        opcode_e op;
        for (int k = 0; k < count; k++) begin
            gen_rng = xorshift(gen_rng);
            op      = opcode_e'(gen_rng[2:0]);
            if (alu_only) begin
                op = opcode_e'(gen_rng[2:0] % 5);  // ALU ops and LDI
            end else if (op == OP_LD) begin
                op = OP_NOP;
            end
            issue(enc(op, gen_rng[5:3], gen_rng[8:6], gen_rng[15:9]));
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (n_checked != n_queued && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n_checked != n_queued) begin
            $display("Timeout: only %0d of %0d trace records arrived within %0d cycles",
                     n_checked, n_queued, TIMEOUT);
            $display("Verification failed");
            $finish;
        end
    endtask

    task automatic begin_test();
        @(posedge clk);
        test_err0 = errors;
    endtask

    task automatic end_test(input int num, input string name);
        wait_drain();
        repeat (10) @(negedge clk);  // Room for stray records to show up
        tests_run++;
        if (errors != test_err0) begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", num, name, errors - test_err0);
        end else begin
            $display("Test %0d %s: ok", num, name);
        end
    endtask

    initial begin : main
        int stalls0;
        for (int k = 0; k < `PIPE_NREG; k++) begin
            m_reg[k] = '0;  // Registers start at zero
        end
        rst = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        begin_test();
        issue_random(40, 1'b1);
        end_test(1, "ALU and LDI results");

        begin_test();
        issue(enc(OP_LDI, 1, 0, 7'h55));
        issue(enc(OP_LDI, 2, 0, 7'h0f));
        issue(enc(OP_ADD, 3, 1, {3'd2, 4'd0}));  // Operands from MEM and WB
        issue(enc(OP_SUB, 4, 3, {3'd1, 4'd0}));
        issue(enc(OP_AND, 5, 4, {3'd3, 4'd0}));
        issue(enc(OP_XOR, 6, 5, {3'd4, 4'd0}));
        issue(enc(OP_ST, 6, 2, 7'd1));           // mem[0]
        issue(enc(OP_LD, 7, 2, 7'd1));           // Same address right behind
        issue(enc(OP_ST, 3, 1, 7'h10));          // mem[5]
        issue(enc(OP_NOP, 0, 0, 7'd0));
        issue(enc(OP_LD, 0, 1, 7'h10));
        issue(enc(OP_XOR, 1, 7, {3'd6, 4'd0}));
        end_test(2, "load and store with forwarding");

        begin_test();
        issue_random(24, 1'b0);  // No loads in this program
        end_test(3, "stage timing");

        begin_test();
        stalls0 = n_stalls;
        issue(enc(OP_LDI, 0, 0, 7'd0));
        issue(enc(OP_LDI, 1, 0, 7'd9));
        issue(enc(OP_ST, 1, 0, 7'd2));
        issue(enc(OP_LD, 2, 0, 7'd2));
        issue(enc(OP_ADD, 3, 1, {3'd2, 4'd0}));  // Uses the load on rt
        issue(enc(OP_LD, 4, 0, 7'd2));
        issue(enc(OP_SUB, 5, 4, {3'd1, 4'd0}));  // Uses the load on rs
        issue(enc(OP_LD, 6, 0, 7'd2));
        issue(enc(OP_ST, 6, 0, 7'd5));           // Store data from the load
        issue(enc(OP_LD, 7, 0, 7'd5));
        issue(enc(OP_LD, 2, 7, 7'd9));           // Address from the load wraps to 2
        wait_drain();
        if (n_stalls - stalls0 < 4) begin
            errors++;
            $display("Only %0d load-use stalls seen where 4 were due", n_stalls - stalls0);
        end
        end_test(4, "load-use stall");

        begin_test();
        hold      = 1'b1;
        hold_recs = 0;
        issue_random(24, 1'b1);
        repeat (100) @(negedge clk);
        @(posedge clk);
        if (hold_recs > TRACE_DEPTH) begin
            errors++;
            $display("FAIL %0t: %0d records arrived without credits, at most %0d allowed",
                     $time, hold_recs, TRACE_DEPTH);
        end
        hold = 1'b0;
        end_test(5, "trace back-pressure");

        begin_test();
        issue_random(19, 1'b0);
        end_test(6, "tags");
        if (exp_q.size() != 0 || rec_q.size() != 0 || n_checked != n_queued) begin
            errors++;
            $display("Sent %0d instructions but checked %0d records", n_queued, n_checked);
        end

        $display("Tests %0d, failed %0d, records %0d, errors %0d", tests_run, tests_failed,
                 n_checked, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+.
pipe_pkg.sv
pipe_fetch.sv
pipe_core.sv
pipe_trace.sv
pipe_top.sv
pipe_chk.sv
tb_pipe.sv

//--- Bender.yml
package:
  name: pipe_trace

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - pipe_pkg.sv
      - pipe_fetch.sv
      - pipe_core.sv
      - pipe_trace.sv
      - pipe_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - pipe_chk.sv
      - tb_pipe.sv
